// ==== common/mem_subsys_pkg.sv ====
`default_nettype none

package mem_subsys_pkg;

  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [DATA_W/8-1:0] sel_t;
  typedef logic [3:0]          lsu_op_t;

  // Bit 3 marks a store, bit 2 an unsigned load, bits 1:0 the size.
  localparam lsu_op_t LSU_OP_LB  = 4'h0;
  localparam lsu_op_t LSU_OP_LH  = 4'h1;
  localparam lsu_op_t LSU_OP_LW  = 4'h2;
  localparam lsu_op_t LSU_OP_LBU = 4'h4;
  localparam lsu_op_t LSU_OP_LHU = 4'h5;
  localparam lsu_op_t LSU_OP_SB  = 4'h8;
  localparam lsu_op_t LSU_OP_SH  = 4'h9;
  localparam lsu_op_t LSU_OP_SW  = 4'ha;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_BUS,
    LSU_DONE
  } lsu_state_t;

endpackage

`default_nettype wire

// ==== lsu/lsu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_core import mem_subsys_pkg::*; (
  input  logic    clk,
  input  logic    arst_n_i,
  input  logic    req_i,
  input  lsu_op_t op_i,
  input  addr_t   addr_i,
  input  word_t   wdata_i,
  output word_t   rdata_o,
  output logic    done_o,
  output logic    busy_o,
  output logic    misaligned_o,
  output logic    wb_cyc_o,
  output logic    wb_stb_o,
  output logic    wb_we_o,
  output addr_t   wb_adr_o,
  output word_t   wb_dat_o,
  output sel_t    wb_sel_o,
  input  word_t   wb_dat_i,
  input  logic    wb_ack_i
);

  lsu_state_t state_q;
  lsu_state_t state_d;
  lsu_op_t    op_q;
  addr_t      addr_q;
  word_t      wdata_q;
  word_t      rdata_q;
  logic       accept;
  logic       is_store;
  logic       misaligned;
  logic [1:0] offset;
  logic [4:0] shamt;
  sel_t       size_mask;
  word_t      lane_data;
  word_t      load_data;

  assign accept   = req_i && (state_q == LSU_IDLE);
  assign offset   = addr_q[1:0];
  assign shamt    = {offset, 3'b000};
  assign is_store = op_q inside {LSU_OP_SB, LSU_OP_SH, LSU_OP_SW};

  always_comb begin
    size_mask  = '0;
    misaligned = 1'b0;
    case (op_q)
      LSU_OP_LB, LSU_OP_LBU, LSU_OP_SB: size_mask = 4'h1;
      LSU_OP_LH, LSU_OP_LHU, LSU_OP_SH: begin
        size_mask  = 4'h3;
        misaligned = offset[0]; // Halfword on an odd byte.
      end
      LSU_OP_LW, LSU_OP_SW: begin
        size_mask  = 4'hf;
        misaligned = |offset;
      end
      default: ;
    endcase
  end

  // Bring the addressed lane down to bit 0, then extend.
  assign lane_data = wb_dat_i >> shamt;

  always_comb begin
    case (op_q)
      LSU_OP_LB:  load_data = {{(DATA_W-8){lane_data[7]}}, lane_data[7:0]};
      LSU_OP_LBU: load_data = {{(DATA_W-8){1'b0}}, lane_data[7:0]};
      LSU_OP_LH:  load_data = {{(DATA_W-16){lane_data[15]}}, lane_data[15:0]};
      LSU_OP_LHU: load_data = {{(DATA_W-16){1'b0}}, lane_data[15:0]};
      default:    load_data = lane_data;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      LSU_IDLE: if (req_i) state_d = LSU_BUS;
      LSU_BUS:  if (misaligned || wb_ack_i) state_d = LSU_DONE; // No bus cycle if misaligned.
      LSU_DONE: state_d = LSU_IDLE;
      default:  state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= LSU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= op_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (wb_cyc_o && wb_ack_i && !is_store) begin
      rdata_q <= load_data;
    end
  end

  assign wb_cyc_o = (state_q == LSU_BUS) && !misaligned;
  assign wb_stb_o = wb_cyc_o;
  assign wb_we_o  = is_store;
  assign wb_adr_o = {addr_q[ADDR_W-1:2], 2'b00}; // Word aligned.
  assign wb_sel_o = sel_t'(size_mask << offset);
  assign wb_dat_o = wdata_q << shamt;

  assign rdata_o      = rdata_q;
  assign done_o       = (state_q == LSU_DONE);
  assign busy_o       = (state_q != LSU_IDLE);
  assign misaligned_o = done_o && misaligned;

endmodule

`default_nettype wire

// ==== logic/fetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import mem_subsys_pkg::*; #(
  parameter addr_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  arst_n_i,
  output word_t instr_o,
  output addr_t instr_pc_o,
  output logic  instr_valid_o,
  input  logic  instr_ready_i,
  input  logic  redirect_i,
  input  addr_t redirect_pc_i,
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output addr_t wb_adr_o,
  input  word_t wb_dat_i,
  input  logic  wb_ack_i
);

  word_t      buf_word [2];
  addr_t      buf_pc [2];
  logic       rd_ptr;
  logic       wr_ptr;
  logic [1:0] count;
  addr_t      fetch_pc;
  addr_t      pend_pc;
  logic       pend;
  logic       pend_epoch;
  logic       epoch;
  logic       push;
  logic       pop;
  logic       start;

  assign pop   = instr_valid_o && instr_ready_i;
  assign push  = pend && wb_ack_i && (pend_epoch == epoch) && !redirect_i;
  assign start = !pend && (count < 2'd2) && !redirect_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count      <= '0;
      rd_ptr     <= 1'b0;
      wr_ptr     <= 1'b0;
      pend       <= 1'b0;
      pend_epoch <= 1'b0;
      epoch      <= 1'b0;
      fetch_pc   <= RESET_PC;
    end else begin
      if (redirect_i) begin
        count    <= '0;
        rd_ptr   <= 1'b0;
        wr_ptr   <= 1'b0;
        epoch    <= ~pend_epoch; // Read in flight now mismatches.
        fetch_pc <= {redirect_pc_i[ADDR_W-1:2], 2'b00};
      end else begin
        if (push) wr_ptr <= ~wr_ptr;
        if (pop) rd_ptr <= ~rd_ptr;
        if (push && !pop) begin
          count <= count + 2'd1;
        end else if (pop && !push) begin
          count <= count - 2'd1;
        end
        if (start) begin
          pend_epoch <= epoch;
          fetch_pc   <= fetch_pc + addr_t'(4);
        end
      end
      if (start) begin
        pend <= 1'b1;
      end else if (pend && wb_ack_i) begin
        pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) pend_pc <= fetch_pc;
    if (push) begin
      buf_word[wr_ptr] <= wb_dat_i;
      buf_pc[wr_ptr]   <= pend_pc;
    end
  end

  assign wb_cyc_o = pend;
  assign wb_stb_o = pend;
  assign wb_adr_o = pend_pc;

  assign instr_valid_o = (count != 2'd0);
  assign instr_o       = buf_word[rd_ptr];
  assign instr_pc_o    = buf_pc[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import mem_subsys_pkg::*; (
  input  logic  clk,
  input  logic  arst_n_i,
  input  logic  m0_cyc_i,
  input  logic  m0_stb_i,
  input  logic  m0_we_i,
  input  addr_t m0_adr_i,
  input  word_t m0_dat_i,
  input  sel_t  m0_sel_i,
  output logic  m0_ack_o,
  output word_t m0_dat_o,
  input  logic  m1_cyc_i,
  input  logic  m1_stb_i,
  input  logic  m1_we_i,
  input  addr_t m1_adr_i,
  input  word_t m1_dat_i,
  input  sel_t  m1_sel_i,
  output logic  m1_ack_o,
  output word_t m1_dat_o,
  output logic  s_cyc_o,
  output logic  s_stb_o,
  output logic  s_we_o,
  output addr_t s_adr_o,
  output word_t s_dat_o,
  output sel_t  s_sel_o,
  input  logic  s_ack_i,
  input  word_t s_dat_i
);

  logic [1:0] gnt_q;
  logic [1:0] gnt_d;
  logic       owner_done;

  // Free bus, or the owner has just dropped cyc.
  assign owner_done = (gnt_q == 2'b00) || (gnt_q[0] && !m0_cyc_i) || (gnt_q[1] && !m1_cyc_i);

  always_comb begin
    gnt_d = gnt_q;
    if (owner_done) begin
      if (m0_cyc_i) begin
        gnt_d = 2'b01;
      end else if (m1_cyc_i) begin
        gnt_d = 2'b10;
      end else begin
        gnt_d = 2'b00;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_q <= 2'b00;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  always_comb begin
    s_cyc_o = 1'b0;
    s_stb_o = 1'b0;
    s_we_o  = 1'b0;
    s_adr_o = '0;
    s_dat_o = '0;
    s_sel_o = '0;
    if (gnt_q[0]) begin
      s_cyc_o = m0_cyc_i;
      s_stb_o = m0_stb_i;
      s_we_o  = m0_we_i;
      s_adr_o = m0_adr_i;
      s_dat_o = m0_dat_i;
      s_sel_o = m0_sel_i;
    end else if (gnt_q[1]) begin
      s_cyc_o = m1_cyc_i;
      s_stb_o = m1_stb_i;
      s_we_o  = m1_we_i;
      s_adr_o = m1_adr_i;
      s_dat_o = m1_dat_i;
      s_sel_o = m1_sel_i;
    end
  end

  assign m0_ack_o = gnt_q[0] && s_ack_i;
  assign m1_ack_o = gnt_q[1] && s_ack_i;
  assign m0_dat_o = gnt_q[0] ? s_dat_i : '0;
  assign m1_dat_o = gnt_q[1] ? s_dat_i : '0;

endmodule

`default_nettype wire

// ==== logic/wb_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_sram import mem_subsys_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic  clk,
  input  logic  arst_n_i,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  word_t wb_dat_i,
  input  sel_t  wb_sel_i,
  output word_t wb_dat_o,
  output logic  wb_ack_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  word_t            mem [MEM_WORDS] = '{default: '0};
  word_t            dat_q;
  logic [IDX_W-1:0] word_idx;
  logic             ack_q;
  logic             access;

  assign word_idx = IDX_W'(wb_adr_i[ADDR_W-1:2] % MEM_WORDS);

  // One access per strobe since the cycle after ack stays quiet.
  assign access = wb_cyc_i && wb_stb_i && !ack_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (wb_we_i) begin
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (wb_sel_i[b]) mem[word_idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
        end
      end
      dat_q <= mem[word_idx]; // Valid together with ack.
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;

endmodule

`default_nettype wire

// ==== logic/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_subsys_pkg::*; #(
  parameter int    MEM_WORDS = 256,
  parameter addr_t RESET_PC  = '0
) (
  input  logic    clk,
  input  logic    arst_n_i,
  input  logic    lsu_req_i,
  input  lsu_op_t lsu_op_i,
  input  addr_t   lsu_addr_i,
  input  word_t   lsu_wdata_i,
  output word_t   lsu_rdata_o,
  output logic    lsu_done_o,
  output logic    lsu_busy_o,
  output logic    lsu_misaligned_o,
  output word_t   instr_o,
  output addr_t   instr_pc_o,
  output logic    instr_valid_o,
  input  logic    instr_ready_i,
  input  logic    redirect_i,
  input  addr_t   redirect_pc_i
);

  logic  m0_cyc, m0_stb, m0_we, m0_ack;
  addr_t m0_adr;
  word_t m0_dat_w, m0_dat_r;
  sel_t  m0_sel;
  logic  m1_cyc, m1_stb, m1_ack;
  addr_t m1_adr;
  word_t m1_dat_r;
  logic  s_cyc, s_stb, s_we, s_ack;
  addr_t s_adr;
  word_t s_dat_w, s_dat_r;
  sel_t  s_sel;

  lsu_core lsu_core_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_i        (lsu_req_i),
    .op_i         (lsu_op_i),
    .addr_i       (lsu_addr_i),
    .wdata_i      (lsu_wdata_i),
    .rdata_o      (lsu_rdata_o),
    .done_o       (lsu_done_o),
    .busy_o       (lsu_busy_o),
    .misaligned_o (lsu_misaligned_o),
    .wb_cyc_o     (m0_cyc),
    .wb_stb_o     (m0_stb),
    .wb_we_o      (m0_we),
    .wb_adr_o     (m0_adr),
    .wb_dat_o     (m0_dat_w),
    .wb_sel_o     (m0_sel),
    .wb_dat_i     (m0_dat_r),
    .wb_ack_i     (m0_ack)
  );

  fetch_buffer #(
    .RESET_PC (RESET_PC)
  ) fetch_buffer_i (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .wb_cyc_o      (m1_cyc),
    .wb_stb_o      (m1_stb),
    .wb_adr_o      (m1_adr),
    .wb_dat_i      (m1_dat_r),
    .wb_ack_i      (m1_ack)
  );

  wb_arbiter wb_arbiter_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .m0_cyc_i (m0_cyc),
    .m0_stb_i (m0_stb),
    .m0_we_i  (m0_we),
    .m0_adr_i (m0_adr),
    .m0_dat_i (m0_dat_w),
    .m0_sel_i (m0_sel),
    .m0_ack_o (m0_ack),
    .m0_dat_o (m0_dat_r),
    .m1_cyc_i (m1_cyc),
    .m1_stb_i (m1_stb),
    .m1_we_i  (1'b0),          // Fetch only reads.
    .m1_adr_i (m1_adr),
    .m1_dat_i ('0),
    .m1_sel_i ('1),
    .m1_ack_o (m1_ack),
    .m1_dat_o (m1_dat_r),
    .s_cyc_o  (s_cyc),
    .s_stb_o  (s_stb),
    .s_we_o   (s_we),
    .s_adr_o  (s_adr),
    .s_dat_o  (s_dat_w),
    .s_sel_o  (s_sel),
    .s_ack_i  (s_ack),
    .s_dat_i  (s_dat_r)
  );

  wb_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) wb_sram_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (s_cyc),
    .wb_stb_i (s_stb),
    .wb_we_i  (s_we),
    .wb_adr_i (s_adr),
    .wb_dat_i (s_dat_w),
    .wb_sel_i (s_sel),
    .wb_dat_o (s_dat_r),
    .wb_ack_o (s_ack)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1; // Released on a falling edge.
  end

endmodule

`default_nettype wire

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_subsys_pkg::*; #(
  parameter int MEM_WORDS = 256,
  parameter int TIMEOUT   = 200
) ();

  localparam int MEM_BYTES = MEM_WORDS * 4;

  logic    clk;
  logic    arst_n;
  logic    lsu_req;
  lsu_op_t lsu_op;
  addr_t   lsu_addr;
  word_t   lsu_wdata;
  word_t   lsu_rdata;
  logic    lsu_done;
  logic    lsu_busy;
  logic    lsu_misaligned;
  word_t   instr;
  addr_t   instr_pc;
  logic    instr_valid;
  logic    instr_ready;
  logic    redirect;
  addr_t   redirect_pc;

  logic [7:0] model_mem [MEM_BYTES];
  addr_t      exp_pc;
  int         bg_count;
  logic       pop_active;
  logic       timed_out;
  int         errors      = 0;
  int         file_errors = 0;
  int         timeouts    = 0;
  int         seed        = 90077;

  tb_clock clock_i (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mem_subsys_top #(
    .MEM_WORDS (MEM_WORDS)
  ) dut_i (
    .clk              (clk),
    .arst_n_i         (arst_n),
    .lsu_req_i        (lsu_req),
    .lsu_op_i         (lsu_op),
    .lsu_addr_i       (lsu_addr),
    .lsu_wdata_i      (lsu_wdata),
    .lsu_rdata_o      (lsu_rdata),
    .lsu_done_o       (lsu_done),
    .lsu_busy_o       (lsu_busy),
    .lsu_misaligned_o (lsu_misaligned),
    .instr_o          (instr),
    .instr_pc_o       (instr_pc),
    .instr_valid_o    (instr_valid),
    .instr_ready_i    (instr_ready),
    .redirect_i       (redirect),
    .redirect_pc_i    (redirect_pc)
  );

  // Byte position in the model folded like the SRAM word index.
  function automatic int byte_index(input addr_t addr);
    return int'(((addr >> 2) % MEM_WORDS) * 4) + int'(addr[1:0]);
  endfunction

  function automatic int access_size(input lsu_op_t op);
    case (op)
      LSU_OP_LB, LSU_OP_LBU, LSU_OP_SB: return 1;
      LSU_OP_LH, LSU_OP_LHU, LSU_OP_SH: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic logic is_store(input lsu_op_t op);
    return (op == LSU_OP_SB) || (op == LSU_OP_SH) || (op == LSU_OP_SW);
  endfunction

  function automatic logic is_misaligned(input lsu_op_t op, input addr_t addr);
    return (addr % access_size(op)) != 0;
  endfunction

  // Little-endian gather of the accessed bytes, then extension.
  function automatic word_t model_read(input lsu_op_t op, input addr_t addr);
    word_t value;
    int    n;
    n     = access_size(op);
    value = '0;
    for (int k = 0; k < n; k++) begin
      value[8*k +: 8] = model_mem[byte_index(addr + addr_t'(k))];
    end
    if (((op == LSU_OP_LB) || (op == LSU_OP_LH)) && value[8*n-1]) begin
      for (int k = n; k < 4; k++) begin
        value[8*k +: 8] = 8'hff;
      end
    end
    return value;
  endfunction

  task automatic model_write(input lsu_op_t op, input addr_t addr, input word_t data);
    for (int k = 0; k < access_size(op); k++) begin
      model_mem[byte_index(addr + addr_t'(k))] = data[8*k +: 8];
    end
  endtask

  function automatic lsu_op_t op_code(input logic [63:0] name);
    case (name)
      64'("LB"):  return LSU_OP_LB;
      64'("LBU"): return LSU_OP_LBU;
      64'("LH"):  return LSU_OP_LH;
      64'("LHU"): return LSU_OP_LHU;
      64'("LW"):  return LSU_OP_LW;
      64'("SB"):  return LSU_OP_SB;
      64'("SH"):  return LSU_OP_SH;
      64'("SW"):  return LSU_OP_SW;
      default:    return 4'hf; // Not an operation.
    endcase
  endfunction

  task automatic lsu_access(input lsu_op_t op, input addr_t addr, input word_t wdata);
    int    cycles;
    logic  mis;
    word_t exp_data;
    mis      = is_misaligned(op, addr);
    exp_data = model_read(op, addr);
    cycles   = 0;
    while (lsu_busy && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (lsu_busy) begin
      $display("Timeout: the LSU stayed busy before the access at %h", addr);
      timeouts++;
      timed_out = 1'b1;
      return;
    end
    lsu_req   = 1'b1;
    lsu_op    = op;
    lsu_addr  = addr;
    lsu_wdata = wdata;
    @(negedge clk);
    lsu_req = 1'b0;
    assert (lsu_busy) else begin
      $display("** Error at %0t ns: the LSU did not turn busy after the request at %h",
               $time, addr);
      errors++;
    end
    cycles  = 0;
    while (!lsu_done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!lsu_done) begin
      $display("Timeout: the LSU gave no done for the access at %h", addr);
      timeouts++;
      timed_out = 1'b1;
      return;
    end
    assert (lsu_misaligned == mis) else begin
      $display("** Error at %0t ns: op %h at %h gave misaligned %b, expected %b",
               $time, op, addr, lsu_misaligned, mis);
      errors++;
    end
    if (!mis && is_store(op)) begin
      model_write(op, addr, wdata);
    end else if (!mis) begin
      assert (lsu_rdata == exp_data) else begin
        $display("** Error at %0t ns: op %h at %h returned %h, expected %h",
                 $time, op, addr, lsu_rdata, exp_data);
        errors++;
      end
    end
  endtask

  // Ready is set on the falling edge and the word pops on the next rising edge.
  task automatic pop_words(input int count, input logic random_stall);
    int   popped;
    int   idle;
    logic ready;
    popped = 0;
    idle   = 0;
    while (popped < count && idle < TIMEOUT) begin
      @(negedge clk);
      ready       = random_stall ? (($random(seed) % 2) != 0) : 1'b1;
      instr_ready = ready;
      if (ready && instr_valid) begin
        assert (instr_pc == exp_pc) else begin
          $display("** Error at %0t ns: fetch gave PC %h, expected %h", $time, instr_pc, exp_pc);
          errors++;
        end
        assert (instr == model_read(LSU_OP_LW, exp_pc)) else begin
          $display("** Error at %0t ns: fetch at %h gave %h, expected %h",
                   $time, exp_pc, instr, model_read(LSU_OP_LW, exp_pc));
          errors++;
        end
        exp_pc = exp_pc + addr_t'(4);
        popped++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    @(negedge clk);
    instr_ready = 1'b0;
    if (popped < count) begin
      $display("Timeout: the fetch buffer delivered %0d of %0d words", popped, count);
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_pop_idle();
    int cycles;
    cycles = 0;
    while (pop_active && cycles < 20 * TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (pop_active) begin
      $display("Timeout: the background fetch check did not finish");
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  task automatic redirect_to(input addr_t pc);
    int cycles;
    cycles = 0;
    while (!instr_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!instr_valid) begin
      $display("Timeout: the fetch buffer never held a word before the redirect");
      timeouts++;
      timed_out = 1'b1;
      return;
    end
    repeat (12) @(negedge clk); // Both entries filled by now.
    redirect    = 1'b1;
    redirect_pc = pc;
    @(negedge clk);
    redirect = 1'b0;
    exp_pc   = {pc[ADDR_W-1:2], 2'b00};
  endtask

  task automatic run_entry(input logic [63:0] kind, input logic [63:0] name, input addr_t addr,
                           input word_t data, input word_t expect_val, input int entry);
    lsu_op_t op;
    op = op_code(name);
    if (kind == 64'("L") && op != 4'hf) begin
      if (!is_store(op) && !is_misaligned(op, addr) && expect_val != model_read(op, addr)) begin
        $display("Data file entry %0d expects %h but the memory model gives %h",
                 entry, expect_val, model_read(op, addr));
        file_errors++;
      end
      lsu_access(op, addr, data);
    end else if (kind == 64'("F")) begin
      wait_pop_idle();
      redirect_to(addr);
    end else if (kind == 64'("P") && (name == 64'("RND") || name == 64'("RDY"))) begin
      wait_pop_idle();
      if (expect_val != exp_pc) begin
        $display("Data file entry %0d expects first PC %h but the next PC is %h",
                 entry, expect_val, exp_pc);
        file_errors++;
      end
      if (name == 64'("RND")) begin
        bg_count   = int'(data);
        pop_active = 1'b1;
        fork
          begin
            pop_words(bg_count, 1'b1);
            pop_active = 1'b0;
          end
        join_none
      end else begin
        pop_words(int'(data), 1'b0);
      end
    end else begin
      $display("Data file entry %0d has an unknown kind or operation", entry);
      file_errors++;
    end
  endtask

  initial begin
    int               fd;
    int               code;
    int               entry;
    int               cycles;
    logic             eof;
    logic [63:0]      kind_s;
    logic [63:0]      op_s;
    logic [8*160-1:0] rest;
    logic [31:0]      f_addr;
    logic [31:0]      f_wdata;
    logic [31:0]      f_exp;
    lsu_req     = 1'b0;
    lsu_op      = LSU_OP_LW;
    lsu_addr    = '0;
    lsu_wdata   = '0;
    instr_ready = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    pop_active  = 1'b0;
    timed_out   = 1'b0;
    exp_pc      = '0;
    entry       = 0;
    eof         = 1'b0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      model_mem[i] = 8'h00; // SRAM starts zeroed.
    end
    @(negedge clk);
    cycles = 0;
    while (!arst_n && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    @(negedge clk);
    if (!arst_n) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end else begin
      fd = $fopen("tb/mem_subsys_testdata.txt", "r");
      if (fd == 0) begin
        $display("Could not open the data file tb/mem_subsys_testdata.txt");
        file_errors++;
      end else begin
        while (!eof && !timed_out) begin
          code = $fscanf(fd, "%s", kind_s);
          if (code != 1) begin
            eof = 1'b1;
          end else if (kind_s == 64'("#")) begin
            code = $fgets(rest, fd); // Skip the comment.
          end else begin
            code = $fscanf(fd, "%s %h %h %h", op_s, f_addr, f_wdata, f_exp);
            entry++;
            if (code != 4) begin
              $display("Data file entry %0d is incomplete", entry);
              file_errors++;
              eof = 1'b1;
            end else begin
              run_entry(kind_s, op_s, f_addr, f_wdata, f_exp, entry);
            end
          end
        end
        $fclose(fd);
        wait_pop_idle();
      end
    end
    $display("Check errors: %0d, file errors: %0d, timeouts: %0d", errors, file_errors, timeouts);
    if (errors == 0 && file_errors == 0 && timeouts == 0 && entry > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/mem_subsys_testdata.txt ====
# kind op addr wdata expect, numbers in hex
# L is an LSU access, expect is the load result; F redirects the fetch to addr
# P pops wdata words with op RDY or RND stall, expect is the first PC
# Stores with a read back of the word
L SW 00000100 8477f2a1 00000000
L LW 00000100 00000000 8477f2a1
L SH 00000100 deadc35a 00000000
L LW 00000100 00000000 8477c35a
L SH 00000102 77771e69 00000000
L LW 00000100 00000000 1e69c35a
L SW 00000104 11223344 00000000
L LW 00000104 00000000 11223344
L SB 00000104 123456aa 00000000
L LW 00000104 00000000 112233aa
L SB 00000105 9999995c 00000000
L LW 00000104 00000000 11225caa
L SB 00000106 000000f0 00000000
L LW 00000104 00000000 11f05caa
L SB 00000107 abcdef8e 00000000
L LW 00000104 00000000 8ef05caa
# Byte and halfword loads, top bit clear and set
L LB 00000100 00000000 0000005a
L LBU 00000100 00000000 0000005a
L LB 00000101 00000000 ffffffc3
L LBU 00000101 00000000 000000c3
L LB 00000102 00000000 00000069
L LBU 00000102 00000000 00000069
L LB 00000103 00000000 0000001e
L LBU 00000103 00000000 0000001e
L LB 00000104 00000000 ffffffaa
L LBU 00000104 00000000 000000aa
L LB 00000105 00000000 0000005c
L LBU 00000105 00000000 0000005c
L LB 00000106 00000000 fffffff0
L LBU 00000106 00000000 000000f0
L LB 00000107 00000000 ffffff8e
L LBU 00000107 00000000 0000008e
L LH 00000100 00000000 ffffc35a
L LHU 00000100 00000000 0000c35a
L LH 00000102 00000000 00001e69
L LHU 00000102 00000000 00001e69
L LH 00000104 00000000 00005caa
L LHU 00000104 00000000 00005caa
L LH 00000106 00000000 ffff8ef0
L LHU 00000106 00000000 00008ef0
# Misaligned accesses leave memory alone
L LH 00000101 00000000 00000000
L LW 00000102 00000000 00000000
L SH 00000103 ffffffff 00000000
L SW 00000101 ffffffff 00000000
L LW 00000100 00000000 1e69c35a
L LW 00000104 00000000 8ef05caa
# Instruction words, then fetch from them
L SW 00000200 00000013 00000000
L SW 00000204 00a00093 00000000
L SW 00000208 01400113 00000000
L SW 0000020c 002081b3 00000000
L SW 00000210 fe31ae23 00000000
L SW 00000214 00108093 00000000
L SW 00000218 ff5ff06f 00000000
L SW 0000021c 0000006f 00000000
F - 00000200 00000000 00000000
P RDY 00000000 00000006 00000200
# Redirect with a full buffer
F - 00000208 00000000 00000000
P RDY 00000000 00000003 00000208
# Random stall on fetch while the LSU runs
F - 00000200 00000000 00000000
P RND 00000000 00000008 00000200
L SW 00000140 cafe0001 00000000
L LH 00000142 00000000 ffffcafe
L SB 00000141 0000007f 00000000
L LW 00000140 00000000 cafe7f01
L LBU 00000143 00000000 000000ca
L SH 00000144 12348001 00000000
L LHU 00000144 00000000 00008001
L LB 00000145 00000000 ffffff80
L LW 00000144 00000000 00008001

// ==== mem_subsys.f ====
common/mem_subsys_pkg.sv
lsu/lsu_core.sv
logic/fetch_buffer.sv
logic/wb_arbiter.sv
logic/wb_sram.sv
logic/mem_subsys_top.sv
tb/tb_clock.sv
tb/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= mem_subsys.f
TB_TOP    ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
